// File: src/icache_pkg.sv
// Instruction cache geometry constants
// Fetch address union with raw and tag/index/offset views
package icache_pkg;

    // Word address and instruction word widths
    localparam int addr_w = 19;
    localparam int data_w = 16;

    // Line geometry
    localparam int line_words = 8;
    localparam int offset_w   = 3;

    // Direct-mapped store depth
    localparam int num_lines = 512;
    localparam int index_w   = 9;

    // Whatever is left above index and offset
    localparam int tag_w = addr_w - index_w - offset_w;

    // Cache view of a word address, MSB first
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } fetch_fields_t;

    // Same 19 bits, seen as the memory port word address
    // or split into fields for the lookup
    typedef union packed {
        logic [addr_w-1:0] word;
        fetch_fields_t     f;
    } fetch_addr_u;

endpackage

// File: src/line_fill_if.sv
// Line-fill write bus between the fill engine and the lookup stores
`timescale 1ns/1ps

interface line_fill_if;

    // Tag write and valid clear for the line being filled
    logic start;
    // One data word arriving from memory
    logic wr;
    logic [icache_pkg::index_w-1:0]  index;
    logic [icache_pkg::offset_w-1:0] offset;
    logic [icache_pkg::tag_w-1:0]    tag;
    // Memory read data, tied to the memory data bus at the top level
    logic [icache_pkg::data_w-1:0]   wdata;
    // Last word of the line, sets the valid bit
    logic done;
    // Words of the current line already written
    logic [icache_pkg::line_words-1:0] word_valid;

    // Fill engine side
    modport fill (output start, wr, index, offset, tag, done, word_valid);

    // Tag, valid and data store side
    modport store (input start, wr, index, offset, tag, wdata, done, word_valid);

endinterface

// File: src/dp_ram.sv
// Synchronous dual-port RAM
// One registered read port and one write port
`timescale 1ns/1ps

module dp_ram #(
    parameter int words = 512,
    parameter int width = 16
) (
    input  logic                     clk,
    // Read port, one cycle latency
    input  logic [$clog2(words)-1:0] raddr,
    output logic [width-1:0]         rdata,
    // Write port
    input  logic                     wr,
    input  logic [$clog2(words)-1:0] waddr,
    input  logic [width-1:0]         wdata
);

    // Storage array
    logic [width-1:0] mem [words];

    // Write side
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= wdata;
        end
    end

    // Read side
    // A read of the word being written returns the old contents
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: src/icache_lookup.sv
// Tag, valid and data stores of the instruction cache
// Hit detection, CPU acknowledge and bypass multiplexing
`timescale 1ns/1ps

module icache_lookup (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enabled,
    input  logic                          c_access,
    input  icache_pkg::fetch_addr_u       c_addr,
    output logic [icache_pkg::data_w-1:0] c_data,
    output logic                          c_ack,
    input  logic [icache_pkg::data_w-1:0] m_data,
    input  logic                          m_ack,
    line_fill_if.store                    fill,
    output logic                          hit
);

    // Registered request, aligned with the RAM read data
    logic                           accessing;
    icache_pkg::fetch_addr_u        req_addr;
    logic                           ack_q;

    // Store outputs
    logic [icache_pkg::tag_w-1:0]   tag_q;
    logic                           valid_q;
    logic [icache_pkg::data_w-1:0]  data_q;

    // Valid store write port, shared by the sweep and the fill
    logic                           valid_wr;
    logic [icache_pkg::index_w-1:0] valid_waddr;
    logic                           valid_wdata;

    // Reset sweep over all valid bits
    logic                           sweep_active;
    logic [icache_pkg::index_w-1:0] sweep_cnt;

    logic ram_hit;
    logic fill_hit;

    // Tags, written once per fill
    dp_ram #(.words(icache_pkg::num_lines), .width(icache_pkg::tag_w)) tag_ram (
        .clk   (clk),
        .raddr (c_addr.f.index),
        .rdata (tag_q),
        .wr    (fill.start),
        .waddr (fill.index),
        .wdata (fill.tag)
    );

    // Sweep wins over fill writes, which at worst costs a refill
    assign valid_wr    = sweep_active | fill.start | fill.done;
    assign valid_waddr = sweep_active ? sweep_cnt : fill.index;
    assign valid_wdata = ~sweep_active & fill.done;

    dp_ram #(.words(icache_pkg::num_lines), .width(1)) valid_ram (
        .clk   (clk),
        .raddr (c_addr.f.index),
        .rdata (valid_q),
        .wr    (valid_wr),
        .waddr (valid_waddr),
        .wdata (valid_wdata)
    );

    // Instruction words, indexed by line and word offset
    dp_ram #(
        .words (icache_pkg::num_lines * icache_pkg::line_words),
        .width (icache_pkg::data_w)
    ) data_ram (
        .clk   (clk),
        .raddr ({c_addr.f.index, c_addr.f.offset}),
        .rdata (data_q),
        .wr    (fill.wr),
        .waddr ({fill.index, fill.offset}),
        .wdata (fill.wdata)
    );

    // Stored line matches
    assign ram_hit  = valid_q && (tag_q == req_addr.f.tag);
    // Line under fill matches and the word is already in
    assign fill_hit = (req_addr.f.tag == fill.tag) && (req_addr.f.index == fill.index) &&
                      fill.word_valid[req_addr.f.offset];
    // No hits until every valid bit is cleared
    assign hit = ~sweep_active && accessing && (ram_hit || fill_hit);

    // Cache output, or memory port straight through in bypass
    assign c_ack  = enabled ? ack_q : m_ack;
    assign c_data = enabled ? data_q : m_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            accessing    <= 1'b0;
            ack_q        <= 1'b0;
            sweep_active <= 1'b1;
            sweep_cnt    <= '0;
        end else begin
            accessing <= c_access;
            // Single-cycle ack, dropped at once with the request
            if (!c_access) begin
                ack_q <= 1'b0;
            end else begin
                ack_q <= enabled && hit && !ack_q;
            end
            if (sweep_active) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                // Last index reached
                if (&sweep_cnt) begin
                    sweep_active <= 1'b0;
                end
            end
        end
    end

    // Address of the request the store outputs belong to
    always_ff @(posedge clk) begin
        req_addr <= c_addr;
    end

endmodule

// File: src/icache_fill.sv
// Miss detection and line-fill sequencer of the instruction cache
// Critical word first, wrapping within the line
`timescale 1ns/1ps

module icache_fill (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enabled,
    input  icache_pkg::fetch_addr_u       c_addr,
    input  logic                          c_access,
    input  logic                          hit,
    output logic [icache_pkg::addr_w-1:0] m_addr,
    output logic                          m_access,
    input  logic                          m_ack,
    line_fill_if.fill                     fill
);

    // Lookup result due for the current request
    logic                            updating;
    // Fill in progress
    logic                            busy;
    // Tag write one cycle after the miss
    logic                            start_q;
    // Words received so far
    logic [icache_pkg::offset_w-1:0] word_cnt;
    // Offset of the word now requested from memory
    logic [icache_pkg::offset_w-1:0] m_offset;
    logic [icache_pkg::line_words-1:0] word_valid;
    // Missed address, held for the whole fill
    icache_pkg::fetch_addr_u         fill_addr;

    logic                            do_fill;
    logic                            wr;
    logic                            done;
    logic [icache_pkg::addr_w-1:0]   fill_m_addr;

    // Miss while idle
    assign do_fill = enabled && updating && !hit && !busy;
    // Every memory ack during a fill is one word
    assign wr      = enabled && busy && m_ack;
    // Eighth word closes the line
    assign done    = wr && (&word_cnt);

    assign fill_m_addr = {fill_addr.f.tag, fill_addr.f.index, m_offset};

    // Bypass hands the CPU request to memory unchanged
    assign m_addr   = enabled ? fill_m_addr : c_addr.word;
    assign m_access = enabled ? busy : c_access;

    // Store side of the fill bus
    assign fill.start      = start_q;
    assign fill.wr         = wr;
    assign fill.index      = fill_addr.f.index;
    assign fill.offset     = m_offset;
    assign fill.tag        = fill_addr.f.tag;
    assign fill.done       = done;
    assign fill.word_valid = word_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            updating   <= 1'b0;
            busy       <= 1'b0;
            start_q    <= 1'b0;
            word_cnt   <= '0;
            word_valid <= '0;
        end else begin
            // One lookup per cycle while a request waits and no fill runs
            updating <= enabled && c_access && !busy;
            start_q  <= do_fill;
            if (do_fill) begin
                busy       <= 1'b1;
                word_cnt   <= '0;
                word_valid <= '0;
            end else if (wr) begin
                word_cnt             <= word_cnt + 1'b1;
                word_valid[m_offset] <= 1'b1;
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Fill address and memory word offset
    always_ff @(posedge clk) begin
        if (do_fill) begin
            fill_addr <= c_addr;
            m_offset  <= c_addr.f.offset;
        end else if (wr) begin
            // Wraps within the line
            m_offset <= m_offset + 1'b1;
        end
    end

endmodule

// File: src/icache_top.sv
// Instruction cache top level
// Lookup stores and fill engine behind plain CPU and memory ports
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          reset,
    // Low selects pass-through to memory
    input  logic                          enabled,

    // CPU fetch port
    input  logic [icache_pkg::addr_w-1:0] c_addr,
    input  logic                          c_access,
    output logic [icache_pkg::data_w-1:0] c_data,
    output logic                          c_ack,

    // Memory port
    output logic [icache_pkg::addr_w-1:0] m_addr,
    output logic                          m_access,
    input  logic [icache_pkg::data_w-1:0] m_data,
    input  logic                          m_ack
);

    // CPU address in its decoded form
    icache_pkg::fetch_addr_u c_addr_u;
    // Lookup result for the registered request
    logic                    hit;

    // Fill writes toward the stores
    line_fill_if fill_bus ();

    assign c_addr_u = icache_pkg::fetch_addr_u'(c_addr);

    // Fill data comes straight from the memory bus
    assign fill_bus.wdata = m_data;

    // Stores, hit logic and CPU side muxing
    icache_lookup u_lookup (
        .clk      (clk),
        .reset    (reset),
        .enabled  (enabled),
        .c_access (c_access),
        .c_addr   (c_addr_u),
        .c_data   (c_data),
        .c_ack    (c_ack),
        .m_data   (m_data),
        .m_ack    (m_ack),
        .fill     (fill_bus.store),
        .hit      (hit)
    );

    // Miss handling and memory reads
    icache_fill u_fill (
        .clk      (clk),
        .reset    (reset),
        .enabled  (enabled),
        .c_addr   (c_addr_u),
        .c_access (c_access),
        .hit      (hit),
        .m_addr   (m_addr),
        .m_access (m_access),
        .m_ack    (m_ack),
        .fill     (fill_bus.fill)
    );

endmodule

// File: test/mem_model.sv
// Behavioral memory for the cache testbench
// Variable read latency, data derived from the word address
`timescale 1ns/1ps

module mem_model (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [icache_pkg::addr_w-1:0] m_addr,
    input  logic                          m_access,
    output logic [icache_pkg::data_w-1:0] m_data,
    output logic                          m_ack
);

    // Read accepted and waiting out its latency
    logic       pending;
    // Cycles left before the ack
    logic [1:0] delay;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
            delay   <= '0;
            m_data  <= '0;
            m_ack   <= 1'b0;
        end else begin
            // Ack is a single-cycle pulse
            m_ack <= 1'b0;
            if (pending) begin
                if (delay == 2'd0) begin
                    m_ack   <= 1'b1;
                    // Word address low half scrambled with a fixed pattern
                    m_data  <= m_addr[15:0] ^ 16'hA5C3;
                    pending <= 1'b0;
                end else begin
                    delay <= delay - 2'd1;
                end
            end else if (m_access && !m_ack) begin
                // Ack lands 1 to 4 cycles after this edge
                pending <= 1'b1;
                delay   <= 2'($urandom_range(3, 0));
            end
        end
    end

endmodule

// File: test/tb_icache.sv
// Instruction cache testbench
// Directed fetch tests with data, memory ack count and hit latency checks
`timescale 1ns/1ps

module tb_icache;

    // About 220 fetches of at most ~55 cycles each, plus the valid sweep
    localparam int max_cycles = 20000;

    logic                          clk;
    logic                          reset;
    logic                          enabled;
    logic [icache_pkg::addr_w-1:0] c_addr;
    logic                          c_access;
    logic [icache_pkg::data_w-1:0] c_data;
    logic                          c_ack;
    logic [icache_pkg::addr_w-1:0] m_addr;
    logic                          m_access;
    logic [icache_pkg::data_w-1:0] m_data;
    logic                          m_ack;

    // Run bookkeeping
    int cycles = 0;
    int ack_count;
    int tests = 0;
    int checks = 0;
    int errors = 0;
    // Counts at the start of the current test or fill
    int test_errors;
    int test_acks;
    // Clock edges from request to c_ack of the last fetch
    int latency;
    // Memory word address of every completed read, in order
    logic [icache_pkg::addr_w-1:0] ack_addrs [$];

    icache_top UUT (.*);

    // Answers fill and bypass reads
    mem_model u_mem (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Memory reads completed
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_count <= 0;
            ack_addrs.delete();
        end else if (m_ack) begin
            ack_count <= ack_count + 1;
            ack_addrs.push_back(m_addr);
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Timeout: a fetch or line fill did not complete after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Memory contents rule
    function automatic logic [icache_pkg::data_w-1:0] mem_word(
        input logic [icache_pkg::addr_w-1:0] addr
    );
        return addr[15:0] ^ 16'hA5C3;
    endfunction

    function automatic icache_pkg::fetch_addr_u make_addr(
        input logic [icache_pkg::tag_w-1:0]    tag,
        input logic [icache_pkg::index_w-1:0]  index,
        input logic [icache_pkg::offset_w-1:0] offset
    );
        icache_pkg::fetch_addr_u a;
        a.f.tag    = tag;
        a.f.index  = index;
        a.f.offset = offset;
        return a;
    endfunction

    task automatic compare_data(input string name, input logic [icache_pkg::data_w-1:0] expected,
                                input logic [icache_pkg::data_w-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_addr(input string name, input logic [icache_pkg::addr_w-1:0] expected,
                                input logic [icache_pkg::addr_w-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // CPU fetch held until c_ack, data checked against the memory rule
    task automatic fetch_and_check(input icache_pkg::fetch_addr_u addr);
        latency = 0;
        @(posedge clk);
        c_addr   <= addr.word;
        c_access <= 1'b1;
        @(negedge clk);
        while (c_ack !== 1'b1) begin
            latency++;
            @(negedge clk);
        end
        compare_data("c_data", mem_word(addr.word), c_data);
        @(posedge clk);
        c_access <= 1'b0;
    endtask

    // Returns at a falling edge with no memory read open
    task automatic wait_memory_idle();
        @(negedge clk);
        while (m_access) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test();
        test_errors = errors;
        wait_memory_idle();
        test_acks = ack_count;
    endtask

    // Memory reads since the last mark, once all are done
    task automatic check_fill_acks(input int expected);
        wait_memory_idle();
        compare_count("m_ack count", expected, ack_count - test_acks);
        test_acks = ack_count;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_errors);
        end
    endtask

    task automatic test_cold_miss();
        start_test();
        fetch_and_check(make_addr(7'h12, 9'h034, 3'd0));
        check_fill_acks(8);
        report_test("cold miss");
    endtask

    // Whole line from the stores, each hit acked two edges after the request
    task automatic test_line_hits();
        int off;
        start_test();
        for (off = 0; off < icache_pkg::line_words; off++) begin
            fetch_and_check(make_addr(7'h12, 9'h034, 3'(off)));
            compare_count("c_ack latency", 2, latency);
        end
        check_fill_acks(0);
        report_test("line hits");
    endtask

    // Same index, other tag evicts, then the first line comes back
    task automatic test_conflict();
        start_test();
        fetch_and_check(make_addr(7'h5A, 9'h034, 3'd2));
        check_fill_acks(8);
        fetch_and_check(make_addr(7'h12, 9'h034, 3'd7));
        check_fill_acks(8);
        report_test("conflict");
    endtask

    // Memory reads of the fill start at the missed word and wrap in the line
    task automatic test_critical_word();
        icache_pkg::fetch_addr_u expected;
        int                      first;
        int                      k;
        start_test();
        first = test_acks;
        fetch_and_check(make_addr(7'h05, 9'h1F0, 3'd5));
        // Fill still running, words arrive 6, 7, 0 .. 4
        fetch_and_check(make_addr(7'h05, 9'h1F0, 3'd6));
        fetch_and_check(make_addr(7'h05, 9'h1F0, 3'd4));
        check_fill_acks(8);
        for (k = 0; k < icache_pkg::line_words; k++) begin
            expected = make_addr(7'h05, 9'h1F0, 3'(5 + k));
            compare_addr("m_addr", expected.word, ack_addrs[first + k]);
        end
        report_test("critical word first");
    endtask

    // Pass-through costs one read even for a cached line
    task automatic test_bypass();
        int n;
        start_test();
        @(posedge clk);
        enabled <= 1'b0;
        for (n = 0; n < 4; n++) begin
            fetch_and_check(make_addr(7'h12 + 7'(n), 9'h034, 3'(n)));
            check_fill_acks(1);
        end
        @(posedge clk);
        enabled <= 1'b1;
        report_test("bypass");
    endtask

    task automatic test_random_fetches();
        logic [icache_pkg::tag_w-1:0] model_tag [icache_pkg::num_lines];
        logic                         model_valid [icache_pkg::num_lines];
        icache_pkg::fetch_addr_u      a;
        int                           misses;
        int                           n;
        start_test();
        misses = 0;
        for (n = 0; n < icache_pkg::num_lines; n++) begin
            model_valid[n] = 1'b0;
        end
        for (n = 0; n < 200; n++) begin
            // Two tags over sixteen lines untouched so far, so lines evict each other
            a = make_addr(7'h40 | 7'($urandom_range(1, 0)), 9'($urandom_range(15, 0)),
                          3'($urandom_range(7, 0)));
            if (!model_valid[a.f.index] || model_tag[a.f.index] != a.f.tag) begin
                misses++;
                model_valid[a.f.index] = 1'b1;
                model_tag[a.f.index]   = a.f.tag;
            end
            fetch_and_check(a);
        end
        check_fill_acks(8 * misses);
        report_test("random fetches");
    endtask

    initial begin
        void'($urandom(95));
        reset    = 1'b1;
        enabled  = 1'b1;
        c_access = 1'b0;
        c_addr   = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // Valid bits clear one line per cycle after reset
        repeat (icache_pkg::num_lines + 8) @(posedge clk);
        test_cold_miss();
        test_line_hits();
        test_conflict();
        test_critical_word();
        test_bypass();
        test_random_fetches();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: flist.f
src/icache_pkg.sv
src/line_fill_if.sv
src/dp_ram.sv
src/icache_lookup.sv
src/icache_fill.sv
src/icache_top.sv
test/mem_model.sv
test/tb_icache.sv

// File: Makefile
# Verilator simulation of the instruction cache

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run the regression"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_icache -Mdir obj_dir -f flist.f
	@out="$$(./obj_dir/Vtb_icache)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
